//--- include/tri_consts.svh
// sizes shared by the triangle generator and its testbench
// TRI_PHASE_BITS must exceed TRI_SAMPLE_WIDTH by at least one bit
`ifndef TRI_CONSTS_SVH
`define TRI_CONSTS_SVH

// independent DAC channels
`define TRI_CHANNELS 4

// samples per channel produced on every dac_clk edge
`define TRI_PARALLEL 4

// phase accumulator width, wraps modulo 2**TRI_PHASE_BITS
`define TRI_PHASE_BITS 32

// signed sample width at the DAC
`define TRI_SAMPLE_WIDTH 16

`endif

//--- source/tri_pkg.sv
// data types for the triangle data path
// lane 0 of every channel is the earliest sample in time
`include "tri_consts.svh"

package tri_pkg;

  // unsigned accumulator phase
  typedef logic [`TRI_PHASE_BITS-1:0] phase_t;

  // signed DAC sample
  typedef logic signed [`TRI_SAMPLE_WIDTH-1:0] sample_t;

  // one phase increment per channel
  typedef phase_t [`TRI_CHANNELS-1:0] inc_word_t;

  // lane phases, indexed [channel][lane]
  typedef struct packed {
    phase_t [`TRI_CHANNELS-1:0][`TRI_PARALLEL-1:0] phase;
  } lane_phases_t;

  // lane samples, indexed [channel][lane]
  typedef struct packed {
    sample_t [`TRI_CHANNELS-1:0][`TRI_PARALLEL-1:0] sample;
  } lane_samples_t;

  // word presented to the DAC each cycle
  typedef struct packed {
    lane_samples_t                data;
    logic [`TRI_CHANNELS-1:0]     trigger;
    logic                         valid;
  } dac_out_t;

endpackage

//--- source/phase_accum.sv
// a load strobe stores all increments and restarts every channel at phase 0
// the base-0 word is registered one cycle after the edge that samples the strobe
`timescale 1ns/1ps
`include "tri_consts.svh"

module phase_accum import tri_pkg::*; (
  input  logic         dac_clk,
  input  logic         arst_n,
  input  inc_word_t    phase_inc,
  input  logic         phase_inc_valid,
  output lane_phases_t lane_phases,
  output logic         phase_ok
);

  localparam int CH = `TRI_CHANNELS;
  localparam int PAR = `TRI_PARALLEL;

  inc_word_t         inc_q;
  phase_t [CH-1:0]   base_q;
  logic              loaded_q;

  // k*inc per lane, plus the per-cycle advance of PAR*inc
  phase_t [CH-1:0][PAR-1:0] offset;
  phase_t [CH-1:0]          step;

  always_comb begin
    for (int c = 0; c < CH; c++) begin
      offset[c][0] = '0;
      for (int k = 1; k < PAR; k++) begin
        offset[c][k] = offset[c][k-1] + inc_q[c];
      end
      step[c] = offset[c][PAR-1] + inc_q[c];
    end
  end

  // increments, base phases and the load flag
  always_ff @(posedge dac_clk or negedge arst_n) begin
    if (!arst_n) begin
      inc_q    <= '0;
      base_q   <= '0;
      loaded_q <= 1'b0;
      phase_ok <= 1'b0;
    end else begin
      // phase_ok trails the load by one cycle, in step with the base-0 word
      phase_ok <= loaded_q;
      if (phase_inc_valid) begin
        inc_q    <= phase_inc;
        base_q   <= '0;
        loaded_q <= 1'b1;
      end else begin
        for (int c = 0; c < CH; c++) begin
          base_q[c] <= base_q[c] + step[c];
        end
      end
    end
  end

  // lane phases, wrapping modulo the accumulator width
  always_ff @(posedge dac_clk) begin
    for (int c = 0; c < CH; c++) begin
      for (int k = 0; k < PAR; k++) begin
        lane_phases.phase[c][k] <= base_q[c] + offset[c][k];
      end
    end
  end

endmodule

//--- source/triangle_shaper.sv
// folds each lane phase into a signed triangle, one register stage
// phase 0 maps to the most negative sample, the fold sits at mid phase
`timescale 1ns/1ps
`include "tri_consts.svh"

module triangle_shaper import tri_pkg::*; (
  input  logic          dac_clk,
  input  logic          arst_n,
  input  lane_phases_t  lane_phases,
  input  logic          phase_ok,
  output lane_samples_t samples,
  output logic          sample_ok
);

  localparam int CH = `TRI_CHANNELS;
  localparam int PAR = `TRI_PARALLEL;
  localparam int PB = `TRI_PHASE_BITS;
  localparam int SW = `TRI_SAMPLE_WIDTH;

  // u is the slice just below the phase MSB
  // rising half uses u, falling half uses ~u, then subtract half range
  function automatic sample_t fold(input phase_t ph);
    logic [SW-1:0] u;
    logic [SW-1:0] f;
    u = ph[PB-2 -: SW];
    f = ph[PB-1] ? ~u : u;
    // minus half range is just an MSB flip
    return {~f[SW-1], f[SW-2:0]};
  endfunction

  lane_samples_t shaped;

  always_comb begin
    for (int c = 0; c < CH; c++) begin
      for (int k = 0; k < PAR; k++) begin
        shaped.sample[c][k] = fold(lane_phases.phase[c][k]);
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    samples <= shaped;
  end

  always_ff @(posedge dac_clk or negedge arst_n) begin
    if (!arst_n) begin
      sample_ok <= 1'b0;
    end else begin
      sample_ok <= phase_ok;
    end
  end

endmodule

//--- source/zero_cross_detect.sv
// flags rising zero crossings, including the boundary between words
// output word only updates while sample_ok is high, so it reads zero until the first load
`timescale 1ns/1ps
`include "tri_consts.svh"

module zero_cross_detect import tri_pkg::*; (
  input  logic          dac_clk,
  input  logic          arst_n,
  input  lane_samples_t samples,
  input  logic          sample_ok,
  output dac_out_t      dac_out
);

  localparam int CH = `TRI_CHANNELS;
  localparam int PAR = `TRI_PARALLEL;
  localparam int SW = `TRI_SAMPLE_WIDTH;

  localparam sample_t MOST_NEG = {1'b1, {(SW-1){1'b0}}};

  // last lane of each channel from the previous valid word
  sample_t [CH-1:0] last_q;

  // sign bits in time order, carried sample first
  logic [CH-1:0][PAR:0] neg;
  logic [CH-1:0]        trig;

  always_comb begin
    for (int c = 0; c < CH; c++) begin
      neg[c][0] = last_q[c][SW-1];
      for (int k = 0; k < PAR; k++) begin
        neg[c][k+1] = samples.sample[c][k][SW-1];
      end
      trig[c] = 1'b0;
      // negative followed by non-negative
      for (int k = 0; k < PAR; k++) begin
        trig[c] = trig[c] | (neg[c][k] & ~neg[c][k+1]);
      end
    end
  end

  always_ff @(posedge dac_clk or negedge arst_n) begin
    if (!arst_n) begin
      last_q  <= {CH{MOST_NEG}};
      dac_out <= '0;
    end else if (sample_ok) begin
      for (int c = 0; c < CH; c++) begin
        last_q[c] <= samples.sample[c][PAR-1];
      end
      dac_out.data    <= samples;
      dac_out.trigger <= trig;
      dac_out.valid   <= 1'b1;
    end else begin
      last_q <= {CH{MOST_NEG}};
    end
  end

endmodule

//--- source/triangle.sv
// multi-channel triangle generator, single dac_clk domain
// dac_out shows the base-0 word 3 cycles after the edge that samples phase_inc_valid
`timescale 1ns/1ps

module triangle import tri_pkg::*; (
  input  logic      dac_clk,
  input  logic      arst_n,
  input  inc_word_t phase_inc,
  input  logic      phase_inc_valid,
  output dac_out_t  dac_out
);

  lane_phases_t  lane_phases;
  logic          phase_ok;
  lane_samples_t samples;
  logic          sample_ok;

  // stage 1: per-lane phases
  phase_accum phase_accum_inst (
    .dac_clk         (dac_clk),
    .arst_n          (arst_n),
    .phase_inc       (phase_inc),
    .phase_inc_valid (phase_inc_valid),
    .lane_phases     (lane_phases),
    .phase_ok        (phase_ok)
  );

  // stage 2: phase to triangle sample
  triangle_shaper triangle_shaper_inst (
    .dac_clk     (dac_clk),
    .arst_n      (arst_n),
    .lane_phases (lane_phases),
    .phase_ok    (phase_ok),
    .samples     (samples),
    .sample_ok   (sample_ok)
  );

  // stage 3: triggers and output word
  zero_cross_detect zero_cross_detect_inst (
    .dac_clk   (dac_clk),
    .arst_n    (arst_n),
    .samples   (samples),
    .sample_ok (sample_ok),
    .dac_out   (dac_out)
  );

endmodule

//--- tb/triangle_tb.sv
// checks triangle against a behavioral model with a fixed 3-cycle load latency
// three loads of random increments with one zero-increment channel in the last
`timescale 1ns/1ps
`include "tri_consts.svh"

module triangle_tb import tri_pkg::*; ();

  localparam int CH = `TRI_CHANNELS;
  localparam int PAR = `TRI_PARALLEL;
  localparam int PB = `TRI_PHASE_BITS;
  localparam int SW = `TRI_SAMPLE_WIDTH;

  localparam int RST_CYCLES = 8;
  localparam int QUIET_CYCLES = 20;
  localparam int LOAD_CYCLES = 600;
  localparam int NUM_LOADS = 3;
  localparam int RUN_CYCLES = RST_CYCLES + QUIET_CYCLES + NUM_LOADS * LOAD_CYCLES;
  // run length rounded up to a multiple of 500 plus 500 cycles of slack
  localparam int MAX_CYCLES = (RUN_CYCLES / 500 + 2) * 500;
  localparam int ZERO_CH = 2;

  localparam sample_t MOST_NEG = {1'b1, {(SW-1){1'b0}}};

  logic      dac_clk = 1'b0;
  logic      arst_n;
  inc_word_t phase_inc;
  logic      phase_inc_valid;
  dac_out_t  dac_out;

  // expected word after each rising edge
  lane_samples_t exp_data;
  logic [CH-1:0] exp_trigger;
  logic          exp_valid;
  logic          exp_first;
  string         exp_name;

  // model state
  phase_t [CH-1:0]  m_base;
  inc_word_t        m_inc;
  logic             m_on;
  sample_t [CH-1:0] m_last;
  logic [2:0]       ld_pipe;
  inc_word_t        ld_inc [0:2];

  string         test_name;
  logic [31:0]   lcg_state;
  logic [CH-1:0] trig_seen = '0;
  int            checks = 0;
  int            err_value = 0;
  int            err_other = 0;
  int            cycles = 0;

  triangle triangle_inst (
    .dac_clk         (dac_clk),
    .arst_n          (arst_n),
    .phase_inc       (phase_inc),
    .phase_inc_valid (phase_inc_valid),
    .dac_out         (dac_out)
  );

  initial begin
    forever #5 dac_clk = ~dac_clk;
  end

  // rises over the low half of the phase circle and falls over the high half
  function automatic sample_t tri_ref(input phase_t ph);
    longint full;
    longint u;
    longint v;
    full = longint'(1) << SW;
    u = (longint'(ph) >> (PB - 1 - SW)) % full;
    if (ph[PB-1]) begin
      v = (full - 1) - u;
    end else begin
      v = u;
    end
    return sample_t'(v - full / 2);
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // increment between 2**20 and 2**24
  task automatic next_inc(output phase_t inc);
    lcg_state = lcg_next(lcg_state);
    inc = phase_t'(lcg_state[31:8]) | phase_t'(32'h0010_0000);
  endtask

  task automatic load_incs(input inc_word_t incs);
    @(negedge dac_clk);
    phase_inc = incs;
    phase_inc_valid = 1'b1;
    @(negedge dac_clk);
    phase_inc_valid = 1'b0;
  endtask

  always @(posedge dac_clk) begin
    sample_t s;
    sample_t prev;
    if (!arst_n) begin
      m_on = 1'b0;
      m_base = '0;
      m_inc = '0;
      m_last = {CH{MOST_NEG}};
      ld_pipe = '0;
      for (int i = 0; i < 3; i++) begin
        ld_inc[i] = '0;
      end
      exp_valid = 1'b0;
      exp_first = 1'b0;
      exp_trigger = '0;
      exp_data = '0;
    end else begin
      // a load sampled three edges ago restarts every channel at phase 0
      exp_first = ld_pipe[2];
      if (ld_pipe[2]) begin
        m_inc = ld_inc[2];
        m_base = '0;
        m_on = 1'b1;
      end else if (m_on) begin
        for (int c = 0; c < CH; c++) begin
          m_base[c] = m_base[c] + phase_t'(PAR) * m_inc[c];
        end
      end
      ld_pipe = {ld_pipe[1:0], phase_inc_valid};
      ld_inc[2] = ld_inc[1];
      ld_inc[1] = ld_inc[0];
      ld_inc[0] = phase_inc;
      exp_valid = m_on;
      exp_trigger = '0;
      exp_data = '0;
      if (m_on) begin
        for (int c = 0; c < CH; c++) begin
          prev = m_last[c];
          for (int k = 0; k < PAR; k++) begin
            s = tri_ref(m_base[c] + phase_t'(k) * m_inc[c]);
            exp_data.sample[c][k] = s;
            if (prev < 0 && s >= 0) begin
              exp_trigger[c] = 1'b1;
            end
            prev = s;
          end
          m_last[c] = prev;
        end
      end
    end
    exp_name = test_name;
  end

  // outputs settle after the rising edge and are compared half a cycle later
  always @(negedge dac_clk) begin
    sample_t exp_s;
    sample_t act_s;
    checks++;
    assert (dac_out.valid === exp_valid) else begin
      err_value++;
      $display("Fail %s: valid expected %0b actual %0b", exp_name, exp_valid, dac_out.valid);
    end
    assert (dac_out.trigger === exp_trigger) else begin
      err_value++;
      $display("Fail %s: trigger expected %b actual %b", exp_name, exp_trigger,
               dac_out.trigger);
    end
    for (int c = 0; c < CH; c++) begin
      for (int k = 0; k < PAR; k++) begin
        exp_s = exp_data.sample[c][k];
        act_s = dac_out.data.sample[c][k];
        assert (act_s === exp_s) else begin
          err_value++;
          $display("Fail %s: ch %0d lane %0d expected %0d actual %0d", exp_name, c, k,
                   exp_s, act_s);
        end
      end
      if (exp_first) begin
        act_s = dac_out.data.sample[c][0];
        assert (act_s === MOST_NEG) else begin
          err_value++;
          $display("Fail %s: ch %0d first lane expected %0d actual %0d", exp_name, c,
                   MOST_NEG, act_s);
        end
      end
    end
    if (dac_out.valid === 1'b1) begin
      trig_seen = trig_seen | dac_out.trigger;
    end
  end

  initial begin
    inc_word_t incs;
    arst_n = 1'b0;
    phase_inc = '0;
    phase_inc_valid = 1'b0;
    test_name = "reset_quiet";
    lcg_state = 32'he7be_01d6;
    repeat (RST_CYCLES) @(negedge dac_clk);
    arst_n = 1'b1;
    repeat (QUIET_CYCLES) @(negedge dac_clk);

    test_name = "first_word";
    for (int c = 0; c < CH; c++) begin
      next_inc(incs[c]);
    end
    load_incs(incs);
    repeat (4) @(negedge dac_clk);
    test_name = "stream";
    repeat (LOAD_CYCLES - 5) @(negedge dac_clk);

    // new increments while the old words are still in flight
    test_name = "reload";
    for (int c = 0; c < CH; c++) begin
      next_inc(incs[c]);
    end
    load_incs(incs);
    repeat (LOAD_CYCLES - 1) @(negedge dac_clk);

    test_name = "zero_inc";
    for (int c = 0; c < CH; c++) begin
      next_inc(incs[c]);
    end
    incs[ZERO_CH] = '0;
    load_incs(incs);
    repeat (LOAD_CYCLES - 1) @(negedge dac_clk);

    assert (trig_seen == '1) else begin
      err_other++;
      $display("some channel never flagged a rising zero crossing: seen %b", trig_seen);
    end
    $display("summary: %0d checks, %0d value errors, %0d other errors", checks, err_value,
             err_other);
    if (err_value + err_other == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge dac_clk);
      cycles++;
    end
    $display("test timed out after %0d cycles", cycles);
    $display("summary: %0d checks, %0d value errors, %0d other errors", checks, err_value,
             err_other + 1);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
source/tri_pkg.sv
source/phase_accum.sv
source/triangle_shaper.sv
source/zero_cross_detect.sv
source/triangle.sv
tb/triangle_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = triangle_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
